// ==== Bender.yml ====
package:
  name: nic_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/nic_pkg.sv
      - design/nic_ctrl_fsm.sv
      - design/rate_window_timer.sv
      - design/packet_counters.sv
      - design/mmio_csr_regs.sv
      - design/nic_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/nic_checker.sv
      - tb/nic_tb.sv

// ==== design/mmio_csr_regs.sv ====
// ==============================
// MMIO register file
// Write decode for the control registers and a registered
// read response covering the feature header and the CSRs
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "nic_cfg.svh"

module mmio_csr_regs import nic_pkg::*; (
    input  logic        ccip_clk,
    input  logic        reset,

    // MMIO requests
    input  logic        mmio_rd_valid,
    input  logic        mmio_wr_valid,
    input  mmio_addr_t  mmio_addr,
    input  mmio_tid_t   mmio_tid,
    input  mmio_data_t  mmio_wr_data,

    // MMIO response
    output logic        mmio_rsp_valid,
    output mmio_tid_t   mmio_rsp_tid,
    output mmio_data_t  mmio_rsp_data,

    // Block side
    input  nic_status_t nic_status,
    input  rate_t       rate,
    input  pkt_count_t  cnt_value,
    output logic        init_req,
    output logic        start_bit,
    output cnt_sel_t    cnt_sel
);

    // ==============================
    // Address map
    // ==============================
    localparam mmio_addr_t ADDR_DFH      = `NIC_DFH_ADDR;
    localparam mmio_addr_t ADDR_AFU_ID_L = `NIC_AFU_ID_L_ADDR;
    localparam mmio_addr_t ADDR_AFU_ID_H = `NIC_AFU_ID_H_ADDR;
    localparam mmio_addr_t ADDR_START    = `NIC_CSR_BASE + `NIC_START;
    localparam mmio_addr_t ADDR_INIT     = `NIC_CSR_BASE + `NIC_INIT;
    localparam mmio_addr_t ADDR_STATUS   = `NIC_CSR_BASE + `NIC_STATUS;
    localparam mmio_addr_t ADDR_RPS      = `NIC_CSR_BASE + `NIC_RPS;
    localparam mmio_addr_t ADDR_CNT_SEL  = `NIC_CSR_BASE + `NIC_CNT_SEL;
    localparam mmio_addr_t ADDR_CNT_VAL  = `NIC_CSR_BASE + `NIC_CNT_VAL;

    localparam logic [127:0] AFU_ID = `NIC_AFU_ID;

    // AFU type in 63:60, end of feature list at bit 40
    localparam mmio_data_t DFH_WORD = {`NIC_DFH_TYPE, 19'd0, 1'b1, 40'd0};

    logic       wr_start;
    logic       wr_init;
    logic       wr_cnt_sel;
    mmio_data_t rd_data;

    // ==============================
    // Write side
    // ==============================
    assign wr_start   = mmio_wr_valid && (mmio_addr == ADDR_START);
    assign wr_init    = mmio_wr_valid && (mmio_addr == ADDR_INIT);
    assign wr_cnt_sel = mmio_wr_valid && (mmio_addr == ADDR_CNT_SEL);

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            init_req  <= 1'b0;
            start_bit <= 1'b0;
            cnt_sel   <= '0;
        end else begin
            // Init is a single-cycle pulse, data ignored
            init_req <= wr_init;
            if (wr_start) begin
                start_bit <= mmio_wr_data[0];
            end
            if (wr_cnt_sel) begin
                cnt_sel <= mmio_wr_data[`NIC_CNT_SEL_W-1:0];
            end
        end
    end

    // ==============================
    // Read side
    // ==============================
    always_comb begin
        case (mmio_addr)
            ADDR_DFH:      rd_data = DFH_WORD;
            ADDR_AFU_ID_L: rd_data = AFU_ID[63:0];
            ADDR_AFU_ID_H: rd_data = AFU_ID[127:64];
            ADDR_STATUS:   rd_data = mmio_data_t'(nic_status);
            ADDR_RPS:      rd_data = mmio_data_t'(rate);
            ADDR_CNT_VAL:  rd_data = mmio_data_t'(cnt_value);
            default:       rd_data = '0;
        endcase
    end

    // Every read is answered on the next cycle
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            mmio_rsp_valid <= 1'b0;
        end else begin
            mmio_rsp_valid <= mmio_rd_valid;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (mmio_rd_valid) begin
            mmio_rsp_tid  <= mmio_tid;
            mmio_rsp_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/nic_cfg.svh ====
// ==============================
// NIC control block configuration
// Register map, field widths, timing and identity constants
// ==============================
`ifndef NIC_CFG_SVH
`define NIC_CFG_SVH

// Field widths
`define NIC_MMIO_ADDR_W   16
`define NIC_MMIO_DATA_W   64
`define NIC_TID_W         9
`define NIC_PKT_CNT_W     64
`define NIC_RATE_W        32
`define NIC_CNT_SEL_W     8
`define NIC_STATUS_W      16

// Feature header space, 64-bit words at even addresses
`define NIC_DFH_ADDR      16'h0000
`define NIC_AFU_ID_L_ADDR 16'h0002
`define NIC_AFU_ID_H_ADDR 16'h0004
`define NIC_DFH_TYPE      4'h1

// CSR block, offsets from the base
`define NIC_CSR_BASE      16'h0010
`define NIC_START         16'd4
`define NIC_INIT          16'd8
`define NIC_STATUS        16'd10
`define NIC_RPS           16'd12
`define NIC_CNT_SEL       16'd14
`define NIC_CNT_VAL       16'd16

// Identity
`define NIC_AFU_ID        128'h5f3a_91c2_07d4_4b6e_a8c1_3e90_d27f_6b15
`define NIC_ID_VALUE      8'h2a

// Timing and sizing
`define NIC_RATE_WINDOW   100
`define NIC_INIT_CYCLES   16
`define NIC_NUM_COUNTERS  4

// Status word layout
`define NIC_ST_ID_MSB     7
`define NIC_ST_ID_LSB     0
`define NIC_ST_READY      8
`define NIC_ST_RUNNING    9
`define NIC_ST_ERROR      10
`define NIC_ST_ERR_RX     11
`define NIC_ST_ERR_TX     12
`define NIC_ST_ERR_CCIP   13

`endif

// ==== design/nic_ctrl_fsm.sv ====
// ==============================
// NIC control FSM
// Init delay, ready/running sequencing, sticky errors
// and the registered status word
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "nic_cfg.svh"

module nic_ctrl_fsm import nic_pkg::*; (
    input  logic        ccip_clk,
    input  logic        reset,
    input  logic        init_req,
    input  logic        start_bit,
    input  logic        err_rx_fifo,
    input  logic        err_tx_fifo,
    input  logic        err_ccip,
    output nic_status_t nic_status,
    output logic        running
);

    localparam int INIT_CNT_W = $clog2(`NIC_INIT_CYCLES + 1);
    localparam logic [INIT_CNT_W-1:0] INIT_LAST = INIT_CNT_W'(`NIC_INIT_CYCLES - 1);

    ctrl_state_t           state;
    ctrl_state_t           state_next;
    logic [INIT_CNT_W-1:0] init_cnt;
    logic                  any_err;
    logic                  err_armed;
    logic                  sticky_rx;
    logic                  sticky_tx;
    logic                  sticky_ccip;
    nic_status_t           status_next;

    assign any_err   = err_rx_fifo | err_tx_fifo | err_ccip;
    // Errors only count once the block has come up
    assign err_armed = (state == CTRL_READY) || (state == CTRL_RUNNING) ||
                       (state == CTRL_ERROR);

    // ==============================
    // State transitions
    // ==============================
    always_comb begin
        state_next = state;
        if (init_req) begin
            state_next = CTRL_INIT;
        end else begin
            case (state)
                CTRL_IDLE: state_next = CTRL_IDLE;
                CTRL_INIT: begin
                    if (init_cnt == INIT_LAST) begin
                        state_next = CTRL_READY;
                    end
                end
                CTRL_READY: begin
                    if (any_err) begin
                        state_next = CTRL_ERROR;
                    end else if (start_bit) begin
                        state_next = CTRL_RUNNING;
                    end
                end
                CTRL_RUNNING: begin
                    if (any_err) begin
                        state_next = CTRL_ERROR;
                    end else if (!start_bit) begin
                        state_next = CTRL_READY;
                    end
                end
                // Left only by a new init request
                CTRL_ERROR: state_next = CTRL_ERROR;
                default: state_next = CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            state <= CTRL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Restarts on every init request
    always_ff @(posedge ccip_clk) begin
        if (reset || init_req || (state != CTRL_INIT)) begin
            init_cnt <= '0;
        end else begin
            init_cnt <= init_cnt + 1'b1;
        end
    end

    // ==============================
    // Sticky errors and status
    // ==============================
    always_ff @(posedge ccip_clk) begin
        if (reset || init_req) begin
            sticky_rx   <= 1'b0;
            sticky_tx   <= 1'b0;
            sticky_ccip <= 1'b0;
        end else if (err_armed) begin
            sticky_rx   <= sticky_rx | err_rx_fifo;
            sticky_tx   <= sticky_tx | err_tx_fifo;
            sticky_ccip <= sticky_ccip | err_ccip;
        end
    end

    always_comb begin
        status_next = '0;
        status_next[`NIC_ST_ID_MSB:`NIC_ST_ID_LSB] = `NIC_ID_VALUE;
        status_next[`NIC_ST_READY]    = (state == CTRL_READY) || (state == CTRL_RUNNING);
        status_next[`NIC_ST_RUNNING]  = (state == CTRL_RUNNING);
        status_next[`NIC_ST_ERROR]    = (state == CTRL_ERROR);
        status_next[`NIC_ST_ERR_RX]   = sticky_rx;
        status_next[`NIC_ST_ERR_TX]   = sticky_tx;
        status_next[`NIC_ST_ERR_CCIP] = sticky_ccip;
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            nic_status <= '0;
        end else begin
            nic_status <= status_next;
        end
    end

    assign running = (state == CTRL_RUNNING);

endmodule

`default_nettype wire

// ==== design/nic_pkg.sv ====
// ==============================
// NIC shared types
// Vector typedefs and the control state encoding
// ==============================
`default_nettype none

`include "nic_cfg.svh"

package nic_pkg;

    // MMIO transport
    typedef logic [`NIC_MMIO_ADDR_W-1:0] mmio_addr_t;
    typedef logic [`NIC_MMIO_DATA_W-1:0] mmio_data_t;
    typedef logic [`NIC_TID_W-1:0]       mmio_tid_t;

    // Statistics
    typedef logic [`NIC_PKT_CNT_W-1:0]   pkt_count_t;
    typedef logic [`NIC_RATE_W-1:0]      rate_t;
    typedef logic [`NIC_CNT_SEL_W-1:0]   cnt_sel_t;

    // Status word, see NIC_ST_* for the layout
    typedef logic [`NIC_STATUS_W-1:0]    nic_status_t;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_INIT,
        CTRL_READY,
        CTRL_RUNNING,
        CTRL_ERROR
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/nic_top.sv ====
// ==============================
// NIC host control top level
// CSR file, control FSM, rate meter and packet counters
// ==============================
`timescale 1ns/1ns
`default_nettype none

module nic_top import nic_pkg::*; (
    input  logic       ccip_clk,
    input  logic       reset,

    // MMIO requests and response
    input  logic       mmio_rd_valid,
    input  logic       mmio_wr_valid,
    input  mmio_addr_t mmio_addr,
    input  mmio_tid_t  mmio_tid,
    input  mmio_data_t mmio_wr_data,
    output logic       mmio_rsp_valid,
    output mmio_tid_t  mmio_rsp_tid,
    output mmio_data_t mmio_rsp_data,

    // Traffic events
    input  logic       rpc_in_valid,
    input  logic       rpc_out_valid,
    input  logic       net_tx_valid,
    input  logic       net_rx_valid,

    // Error flags from the datapath
    input  logic       err_rx_fifo,
    input  logic       err_tx_fifo,
    input  logic       err_ccip
);

    logic        init_req;
    logic        start_bit;
    logic        running;
    nic_status_t nic_status;
    rate_t       rate;
    cnt_sel_t    cnt_sel;
    pkt_count_t  cnt_value;

    mmio_csr_regs u_csr (
        .ccip_clk       (ccip_clk),
        .reset          (reset),
        .mmio_rd_valid  (mmio_rd_valid),
        .mmio_wr_valid  (mmio_wr_valid),
        .mmio_addr      (mmio_addr),
        .mmio_tid       (mmio_tid),
        .mmio_wr_data   (mmio_wr_data),
        .mmio_rsp_valid (mmio_rsp_valid),
        .mmio_rsp_tid   (mmio_rsp_tid),
        .mmio_rsp_data  (mmio_rsp_data),
        .nic_status     (nic_status),
        .rate           (rate),
        .cnt_value      (cnt_value),
        .init_req       (init_req),
        .start_bit      (start_bit),
        .cnt_sel        (cnt_sel)
    );

    nic_ctrl_fsm u_fsm (
        .ccip_clk    (ccip_clk),
        .reset       (reset),
        .init_req    (init_req),
        .start_bit   (start_bit),
        .err_rx_fifo (err_rx_fifo),
        .err_tx_fifo (err_tx_fifo),
        .err_ccip    (err_ccip),
        .nic_status  (nic_status),
        .running     (running)
    );

    rate_window_timer u_rate (
        .ccip_clk     (ccip_clk),
        .reset        (reset),
        .running      (running),
        .rpc_in_valid (rpc_in_valid),
        .rate         (rate)
    );

    packet_counters u_cnt (
        .ccip_clk      (ccip_clk),
        .reset         (reset),
        .running       (running),
        .rpc_in_valid  (rpc_in_valid),
        .rpc_out_valid (rpc_out_valid),
        .net_tx_valid  (net_tx_valid),
        .net_rx_valid  (net_rx_valid),
        .cnt_sel       (cnt_sel),
        .cnt_value     (cnt_value)
    );

endmodule

`default_nettype wire

// ==== design/packet_counters.sv ====
// ==============================
// Packet counters
// Four 64-bit event counters with selectable readout
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "nic_cfg.svh"

module packet_counters import nic_pkg::*; (
    input  logic       ccip_clk,
    input  logic       reset,
    input  logic       running,
    input  logic       rpc_in_valid,
    input  logic       rpc_out_valid,
    input  logic       net_tx_valid,
    input  logic       net_rx_valid,
    input  cnt_sel_t   cnt_sel,
    output pkt_count_t cnt_value
);

    localparam int IDX_W = $clog2(`NIC_NUM_COUNTERS);

    pkt_count_t                   counters [`NIC_NUM_COUNTERS];
    logic [`NIC_NUM_COUNTERS-1:0] evt;

    // Index order matches the selector values
    assign evt = {net_rx_valid, net_tx_valid, rpc_out_valid, rpc_in_valid};

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            for (int i = 0; i < `NIC_NUM_COUNTERS; i++) begin
                counters[i] <= '0;
            end
        end else if (running) begin
            for (int i = 0; i < `NIC_NUM_COUNTERS; i++) begin
                if (evt[i]) begin
                    counters[i] <= counters[i] + 1'b1;
                end
            end
        end
    end

    // Out-of-range selector reads as zero
    always_comb begin
        cnt_value = '0;
        if (cnt_sel < cnt_sel_t'(`NIC_NUM_COUNTERS)) begin
            cnt_value = counters[cnt_sel[IDX_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== design/rate_window_timer.sv ====
// ==============================
// Request rate meter
// Counts rpc_in strobes over fixed windows and
// publishes the total at each window boundary
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "nic_cfg.svh"

module rate_window_timer import nic_pkg::*; (
    input  logic  ccip_clk,
    input  logic  reset,
    input  logic  running,
    input  logic  rpc_in_valid,
    output rate_t rate
);

    localparam int WIN_W = $clog2(`NIC_RATE_WINDOW);
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`NIC_RATE_WINDOW - 1);

    logic [WIN_W-1:0] win_cnt;
    rate_t            acc;
    logic             evt;
    logic             win_end;

    // Only requests seen while running are counted
    assign evt     = running & rpc_in_valid;
    assign win_end = (win_cnt == WIN_LAST);

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            win_cnt <= '0;
            acc     <= '0;
            rate    <= '0;
        end else if (win_end) begin
            // Last cycle of the window still belongs to it
            win_cnt <= '0;
            rate    <= acc + rate_t'(evt);
            acc     <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            if (evt) begin
                acc <= acc + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/nic_pkg.sv
design/nic_ctrl_fsm.sv
design/rate_window_timer.sv
design/packet_counters.sv
design/mmio_csr_regs.sv
design/nic_top.sv
tb/nic_checker.sv
tb/nic_tb.sv

// ==== tb/nic_checker.sv ====
// ==============================
// NIC control block checker
// Concurrent assertions on MMIO responses, status
// sequencing and sticky errors, bound to nic_top
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "nic_cfg.svh"

module nic_checker import nic_pkg::*; (
    input logic        ccip_clk,
    input logic        reset,
    input logic        mmio_rd_valid,
    input mmio_tid_t   mmio_tid,
    input logic        mmio_rsp_valid,
    input mmio_tid_t   mmio_rsp_tid,
    input mmio_data_t  mmio_rsp_data,
    input logic        err_ccip,
    input logic        init_req,
    input logic        running,
    input nic_status_t nic_status,
    input mmio_data_t  exp_data
);

    localparam int INIT_N = `NIC_INIT_CYCLES;

    int        fail_count = 0;
    mmio_tid_t req_tid;

    // Tag presented on the previous cycle
    always_ff @(posedge ccip_clk) begin
        req_tid <= mmio_tid;
    end

    // ==============================
    // MMIO response
    // ==============================
    a_rsp_timing: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_rd_valid |=> mmio_rsp_valid)
    else begin
        fail_count++;
        $error("Read request was not answered on the next cycle");
    end

    a_rsp_tid: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_rsp_valid |-> (mmio_rsp_tid == req_tid))
    else begin
        fail_count++;
        $error("** Error %0t: mmio_rsp_tid = %h, expected %h", $time, mmio_rsp_tid, req_tid);
    end

    a_rsp_data: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_rsp_valid |-> (mmio_rsp_data == exp_data))
    else begin
        fail_count++;
        $error("** Error %0t: mmio_rsp_data = %h, expected %h", $time, mmio_rsp_data, exp_data);
    end

    // ==============================
    // Control sequencing
    // ==============================
    // Ready shows two cycles after the init delay ends
    a_ready_timing: assert property (@(posedge ccip_clk) disable iff (reset)
        init_req ##1 (!init_req) [*INIT_N + 1] |=> nic_status[`NIC_ST_READY])
    else begin
        fail_count++;
        $error("Ready status did not follow the init delay");
    end

    a_err_stops: assert property (@(posedge ccip_clk) disable iff (reset)
        err_ccip && running && !init_req |=> !running ##1
        (nic_status[`NIC_ST_ERROR] && nic_status[`NIC_ST_ERR_CCIP]))
    else begin
        fail_count++;
        $error("CCI-P error did not stop the block or set the error bits");
    end

    a_err_sticky: assert property (@(posedge ccip_clk) disable iff (reset)
        nic_status[`NIC_ST_ERR_CCIP] && !$past(init_req) |=> nic_status[`NIC_ST_ERR_CCIP])
    else begin
        fail_count++;
        $error("CCI-P error bit dropped without an init request");
    end

    a_reset_quiet: assert property (@(posedge ccip_clk)
        reset |=> !mmio_rsp_valid && !init_req && !running)
    else begin
        fail_count++;
        $error("Outputs active right after reset");
    end

endmodule

`default_nettype wire

// ==== tb/nic_tb.sv ====
// ==============================
// NIC control block testbench
// Drives MMIO traffic and event strobes; the bound
// checker compares responses with expected values
// ==============================
`timescale 1ns/1ns
`default_nettype none

`include "nic_cfg.svh"

module nic_tb import nic_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int RST_CYCLES  = 8;
    localparam int RSP_TIMEOUT = 8;
    localparam int WIN         = `NIC_RATE_WINDOW;
    localparam int WATCHDOG_NS = 40 * WIN * CLK_PERIOD;

    localparam mmio_addr_t A_START   = `NIC_CSR_BASE + `NIC_START;
    localparam mmio_addr_t A_INIT    = `NIC_CSR_BASE + `NIC_INIT;
    localparam mmio_addr_t A_STATUS  = `NIC_CSR_BASE + `NIC_STATUS;
    localparam mmio_addr_t A_RPS     = `NIC_CSR_BASE + `NIC_RPS;
    localparam mmio_addr_t A_CNT_SEL = `NIC_CSR_BASE + `NIC_CNT_SEL;
    localparam mmio_addr_t A_CNT_VAL = `NIC_CSR_BASE + `NIC_CNT_VAL;

    logic       ccip_clk;
    logic       reset;
    logic       mmio_rd_valid;
    logic       mmio_wr_valid;
    mmio_addr_t mmio_addr;
    mmio_tid_t  mmio_tid;
    mmio_data_t mmio_wr_data;
    logic       mmio_rsp_valid;
    mmio_tid_t  mmio_rsp_tid;
    mmio_data_t mmio_rsp_data;
    logic       rpc_in_valid;
    logic       rpc_out_valid;
    logic       net_tx_valid;
    logic       net_rx_valid;
    logic       err_rx_fifo;
    logic       err_tx_fifo;
    logic       err_ccip;

    // Expected data of the read in flight
    mmio_data_t  exp_data;
    logic [31:0] lfsr;
    pkt_count_t  sent [`NIC_NUM_COUNTERS];
    int          tb_errors;
    int          reads;

    nic_top dut (
        .ccip_clk       (ccip_clk),
        .reset          (reset),
        .mmio_rd_valid  (mmio_rd_valid),
        .mmio_wr_valid  (mmio_wr_valid),
        .mmio_addr      (mmio_addr),
        .mmio_tid       (mmio_tid),
        .mmio_wr_data   (mmio_wr_data),
        .mmio_rsp_valid (mmio_rsp_valid),
        .mmio_rsp_tid   (mmio_rsp_tid),
        .mmio_rsp_data  (mmio_rsp_data),
        .rpc_in_valid   (rpc_in_valid),
        .rpc_out_valid  (rpc_out_valid),
        .net_tx_valid   (net_tx_valid),
        .net_rx_valid   (net_rx_valid),
        .err_rx_fifo    (err_rx_fifo),
        .err_tx_fifo    (err_tx_fifo),
        .err_ccip       (err_ccip)
    );

    bind nic_top nic_checker chk (
        .ccip_clk       (ccip_clk),
        .reset          (reset),
        .mmio_rd_valid  (mmio_rd_valid),
        .mmio_tid       (mmio_tid),
        .mmio_rsp_valid (mmio_rsp_valid),
        .mmio_rsp_tid   (mmio_rsp_tid),
        .mmio_rsp_data  (mmio_rsp_data),
        .err_ccip       (err_ccip),
        .init_req       (init_req),
        .running        (running),
        .nic_status     (nic_status),
        .exp_data       (nic_tb.exp_data)
    );

    always #(CLK_PERIOD / 2) ccip_clk = ~ccip_clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic mmio_data_t status_word(input logic ready, input logic run,
                                               input logic error, input logic ccip);
        mmio_data_t word;
        word = '0;
        word[`NIC_ST_ID_MSB:`NIC_ST_ID_LSB] = `NIC_ID_VALUE;
        word[`NIC_ST_READY]    = ready;
        word[`NIC_ST_RUNNING]  = run;
        word[`NIC_ST_ERROR]    = error;
        word[`NIC_ST_ERR_CCIP] = ccip;
        return word;
    endfunction

    task automatic next_cycle();
        @(posedge ccip_clk);
        #DRIVE_DLY;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic mmio_write(input mmio_addr_t addr, input mmio_data_t data);
        mmio_wr_valid = 1'b1;
        mmio_addr     = addr;
        mmio_wr_data  = data;
        next_cycle();
        mmio_wr_valid = 1'b0;
    endtask

    task automatic mmio_read(input mmio_addr_t addr, input mmio_data_t expected);
        int waited;
        waited        = 0;
        mmio_rd_valid = 1'b1;
        mmio_addr     = addr;
        mmio_tid      = mmio_tid_t'(rand_bits(`NIC_TID_W));
        exp_data      = expected;
        next_cycle();
        mmio_rd_valid = 1'b0;
        while (!mmio_rsp_valid && waited < RSP_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!mmio_rsp_valid) begin
            $display("No read response for address %h within %0d cycles", addr, RSP_TIMEOUT);
            tb_errors++;
        end
        // Checker samples the response on this edge
        next_cycle();
        reads++;
    endtask

    task automatic random_strobes(input int cycles, input logic counting);
        logic [3:0] pick;
        repeat (cycles) begin
            pick = 4'(rand_bits(4));
            {net_rx_valid, net_tx_valid, rpc_out_valid, rpc_in_valid} = pick;
            for (int i = 0; i < `NIC_NUM_COUNTERS; i++) begin
                if (counting && pick[i]) begin
                    sent[i]++;
                end
            end
            next_cycle();
        end
        {net_rx_valid, net_tx_valid, rpc_out_valid, rpc_in_valid} = 4'b0;
    endtask

    task automatic check_counters();
        for (int i = 0; i < `NIC_NUM_COUNTERS; i++) begin
            mmio_write(A_CNT_SEL, mmio_data_t'(i));
            mmio_read(A_CNT_VAL, sent[i]);
        end
    endtask

    task automatic rpc_every_fourth(input int pulses);
        repeat (pulses) begin
            rpc_in_valid = 1'b1;
            next_cycle();
            rpc_in_valid = 1'b0;
            idle(3);
        end
    endtask

    task automatic pulse_err_ccip();
        err_ccip = 1'b1;
        next_cycle();
        err_ccip = 1'b0;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        mmio_data_t   dfh;
        logic [127:0] afu_id;
        int           total;
        ccip_clk      = 1'b0;
        reset         = 1'b1;
        mmio_rd_valid = 1'b0;
        mmio_wr_valid = 1'b0;
        mmio_addr     = '0;
        mmio_tid      = '0;
        mmio_wr_data  = '0;
        {net_rx_valid, net_tx_valid, rpc_out_valid, rpc_in_valid} = 4'b0;
        {err_rx_fifo, err_tx_fifo, err_ccip} = 3'b0;
        exp_data      = '0;
        lfsr          = 32'h29ca_2783;
        tb_errors     = 0;
        reads         = 0;
        for (int i = 0; i < `NIC_NUM_COUNTERS; i++) begin
            sent[i] = '0;
        end
        dfh         = '0;
        dfh[63:60]  = `NIC_DFH_TYPE;
        dfh[40]     = 1'b1;
        afu_id      = `NIC_AFU_ID;

        repeat (RST_CYCLES) @(posedge ccip_clk);
        #DRIVE_DLY;
        reset = 1'b0;

        // Feature header and unmapped space
        mmio_read(`NIC_DFH_ADDR, dfh);
        mmio_read(`NIC_AFU_ID_L_ADDR, afu_id[63:0]);
        mmio_read(`NIC_AFU_ID_H_ADDR, afu_id[127:64]);
        mmio_read(16'h0006, '0);
        mmio_read(16'h0040, '0);
        mmio_read(A_STATUS, status_word(1'b0, 1'b0, 1'b0, 1'b0));

        // Bring up, strobes while stopped leave counters at zero
        mmio_write(A_INIT, '0);
        idle(`NIC_INIT_CYCLES + 3);
        mmio_read(A_STATUS, status_word(1'b1, 1'b0, 1'b0, 1'b0));
        random_strobes(100, 1'b0);
        check_counters();

        mmio_write(A_START, 64'd1);
        idle(2);
        mmio_read(A_STATUS, status_word(1'b1, 1'b1, 1'b0, 1'b0));
        mmio_write(A_START, 64'd0);
        idle(2);
        mmio_read(A_STATUS, status_word(1'b1, 1'b0, 1'b0, 1'b0));

        // Counting while running
        mmio_write(A_START, 64'd1);
        idle(2);
        random_strobes(200, 1'b1);
        check_counters();
        mmio_write(A_CNT_SEL, 64'd7);
        mmio_read(A_CNT_VAL, '0);

        // Steady request rate, read after two full windows
        fork
            rpc_every_fourth(3 * WIN / 4);
            begin
                idle(2 * WIN + 10);
                mmio_read(A_RPS, mmio_data_t'(WIN / 4));
            end
        join

        // Sticky CCI-P error, cleared by a new init
        pulse_err_ccip();
        idle(2);
        mmio_read(A_STATUS, status_word(1'b0, 1'b0, 1'b1, 1'b1));
        idle(20);
        mmio_read(A_STATUS, status_word(1'b0, 1'b0, 1'b1, 1'b1));
        mmio_write(A_START, 64'd0);
        mmio_write(A_INIT, '0);
        idle(`NIC_INIT_CYCLES + 3);
        mmio_read(A_STATUS, status_word(1'b1, 1'b0, 1'b0, 1'b0));

        total = tb_errors + dut.chk.fail_count;
        $display("Reads %0d, checker errors %0d, testbench errors %0d",
                 reads, dut.chk.fail_count, tb_errors);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the sequence finished", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
